//--- periph_hub.f
+incdir+.
periph_bus_pkg.sv
periph_pin_pkg.sv
periph_addr_decode.sv
gpio_periph.sv
byte_reg_periph.sv
read_return.sv
pin_output_mux.sv
periph_hub.sv
periph_hub_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = periph_hub_tb
FILELIST  = periph_hub.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- periph_hub_tb.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module periph_hub_tb;

    import periph_bus_pkg::*;
    import periph_pin_pkg::*;

    localparam int TIMEOUT     = 20;
    localparam int HOLD_CYCLES = 4;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PINS, OP_OUT, OP_HOLD} op_e;

    // One table row with the operation and the value it should produce
    typedef struct packed {
        op_e                   op;
        logic [`PH_ADDR_W-1:0] addr;
        logic [`PH_DATA_W-1:0] data;
        logic [`PH_DATA_W-1:0] exp;
    } test_op_t;

    logic                  clk;
    logic                  rst_n;
    pin_vec_t              ui_in;
    pin_vec_t              uo_out;
    logic [`PH_ADDR_W-1:0] core_addr;
    logic [`PH_DATA_W-1:0] core_wdata;
    access_size_e          write_n;
    access_size_e          read_n;
    logic                  read_complete;
    logic [`PH_DATA_W-1:0] rdata;
    logic                  data_ready;

    test_op_t    ops[$];
    string       names[$];
    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    logic [16:0] lfsr_q;

    // Reference state that follows the register map while the table is built
    pin_vec_t   m_gpio_out;
    pin_vec_t   m_byte_out [2];
    logic [4:0] m_fsel [8];
    pin_vec_t   m_ui;

    periph_hub dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .o_uo_out        (uo_out),
        .i_addr          (core_addr),
        .i_wdata         (core_wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_rdata         (rdata),
        .o_data_ready    (data_ready)
    );

    always #4 clk = ~clk;

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] v;
        for (int i = 0; i < 4; i++) begin
            v = {v[23:0], rand_byte()};
        end
        return v;
    endfunction

    function automatic logic [10:0] waddr(input int slot, input int ofs);
        return {1'b0, 4'(slot), 6'(ofs)};
    endfunction

    function automatic logic [10:0] baddr(input int slot, input int ofs);
        return {1'b1, 2'b00, 4'(slot), 4'(ofs)};
    endfunction

    function automatic logic [31:0] expected_rdata(input logic [10:0] a);
        int ofs;
        logic [31:0] v;
        v = '0;
        if (a[10] && a[7:4] < 2) begin
            ofs = int'(a[3:0]);
            if (ofs == 0) v = {24'b0, m_byte_out[a[4]]};
            if (ofs == 1) v = {24'b0, m_ui};
        end else if (!a[10] && a[9:6] == 4'd1) begin
            ofs = int'(a[5:0]);
            if (ofs == 0) v = {24'b0, m_gpio_out};
            if (ofs == 4) v = {24'b0, m_ui};
            if (ofs >= 32 && ofs % 4 == 0) v = {27'b0, m_fsel[(ofs - 32) / 4]};
        end
        return v;
    endfunction

    // Word slot 1 is GPIO, byte slots 0 and 1 exist, anything else drives low
    function automatic logic [7:0] routed_pins();
        logic [7:0] v;
        for (int p = 0; p < 8; p++) begin
            case (m_fsel[p])
                5'h01:   v[p] = m_gpio_out[p];
                5'h10:   v[p] = m_byte_out[0][p];
                5'h11:   v[p] = m_byte_out[1][p];
                default: v[p] = 1'b0;
            endcase
        end
        return v;
    endfunction

    task automatic push_op(input string name, input op_e op, input logic [10:0] a,
                           input logic [31:0] data, input logic [31:0] exp);
        ops.push_back('{op: op, addr: a, data: data, exp: exp});
        names.push_back(name);
    endtask

    task automatic queue_write(input string name, input logic [10:0] a, input logic [31:0] data);
        int ofs;
        ofs = int'(a[5:0]);
        if (!a[10] && a[9:6] == 4'd1) begin
            if (ofs == 0) m_gpio_out = data[7:0];
            if (ofs >= 32 && ofs % 4 == 0) m_fsel[(ofs - 32) / 4] = data[4:0];
        end else if (a[10] && a[7:4] < 2 && a[3:0] == 4'd0) begin
            m_byte_out[a[4]] = data[7:0];
        end
        push_op(name, OP_WRITE, a, data, '0);
    endtask

    task automatic expect_read(input string name, input logic [10:0] a);
        push_op(name, OP_READ, a, '0, expected_rdata(a));
    endtask

    task automatic change_pins(input string name, input logic [7:0] v);
        m_ui = v;
        push_op(name, OP_PINS, '0, {24'b0, v}, '0);
    endtask

    task automatic check_pin_out(input string name);
        push_op(name, OP_OUT, '0, '0, {24'b0, routed_pins()});
    endtask

    // Captured value must survive a pin change until read complete
    task automatic hold_read(input string name, input logic [10:0] a, input logic [7:0] new_ui);
        push_op(name, OP_HOLD, a, {24'b0, new_ui}, expected_rdata(a));
        m_ui = new_ui;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            n_errors++;
        end
    endtask

    task automatic write_word(input string name, input logic [10:0] a, input logic [31:0] data);
        @(posedge clk);
        core_addr  <= a;
        core_wdata <= data;
        write_n    <= ACC_WORD;
        @(negedge clk);
        check_value({name, " ready"}, 32'd1, {31'b0, data_ready});
        @(posedge clk);
        write_n <= ACC_NONE;
    endtask

    task automatic read_and_check(input string name, input logic [10:0] a,
                                  input logic [31:0] exp, input bit hold, input logic [7:0] new_ui);
        int waited;
        waited = 0;
        @(posedge clk);
        core_addr <= a;
        read_n    <= ACC_WORD;
        @(negedge clk);
        while (!data_ready && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        assert (data_ready) else begin
            $display("Timed out waiting for data ready on read %s", name);
            n_timeouts++;
        end
        if (data_ready) begin
            check_value({name, " latency"}, 32'd1, waited);
            check_value(name, exp, rdata);
            if (hold) begin
                @(posedge clk);
                ui_in <= new_ui;
                for (int c = 0; c < HOLD_CYCLES; c++) begin
                    @(negedge clk);
                    check_value({name, " held"}, exp, rdata);
                end
            end
        end
        @(posedge clk);
        read_n        <= ACC_NONE;
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    initial begin
        logic [4:0]  sel;
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = '0;
        core_addr     = '0;
        core_wdata    = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        n_checks      = 0;
        n_errors      = 0;
        n_timeouts    = 0;
        lfsr_q        = 17'd77226;
        m_gpio_out    = '0;
        m_byte_out    = '{default: '0};
        m_ui          = '0;
        // Every pin starts on word slot 1
        m_fsel        = '{default: 5'h01};

        check_pin_out("reset pins");
        for (int p = 0; p < 8; p++) begin
            expect_read($sformatf("reset fsel %0d", p), waddr(1, 32 + 4 * p));
        end

        change_pins("ui first", rand_byte());
        queue_write("gpio out write", waddr(1, 0), rand_word());
        check_pin_out("gpio pins");
        expect_read("gpio out", waddr(1, 0));
        expect_read("gpio in", waddr(1, 4));
        expect_read("gpio gap", waddr(1, 8));
        expect_read("word slot 2", waddr(2, 0));

        queue_write("byte0 write", baddr(0, 0), rand_word());
        queue_write("byte1 write", baddr(1, 0), rand_word());
        expect_read("byte0 out", baddr(0, 0));
        expect_read("byte1 out", baddr(1, 0));
        change_pins("ui second", rand_byte());
        expect_read("byte0 in", baddr(0, 1));
        expect_read("byte1 in", baddr(1, 1));
        expect_read("byte1 gap", baddr(1, 5));
        expect_read("byte slot 7", baddr(7, 0));

        // Pins 0-3 from byte slot 0, 4-5 from byte slot 1, 6 GPIO, 7 an absent slot
        for (int p = 0; p < 8; p++) begin
            sel = (p < 4) ? 5'h10 : (p < 6) ? 5'h11 : (p == 6) ? 5'h01 : 5'h15;
            queue_write($sformatf("fsel %0d write", p), waddr(1, 32 + 4 * p),
                        {19'b0, rand_byte(), sel});
        end
        check_pin_out("routed pins");
        expect_read("fsel 7", waddr(1, 60));

        hold_read("held read", waddr(1, 4), m_ui ^ (rand_byte() | 8'h01));
        expect_read("after hold", waddr(1, 4));

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        foreach (ops[i]) begin
            case (ops[i].op)
                OP_WRITE: write_word(names[i], ops[i].addr, ops[i].data);
                OP_READ:  read_and_check(names[i], ops[i].addr, ops[i].exp, 1'b0, 8'h00);
                OP_HOLD:  read_and_check(names[i], ops[i].addr, ops[i].exp, 1'b1, ops[i].data[7:0]);
                OP_PINS: begin
                    @(posedge clk);
                    ui_in <= ops[i].data[7:0];
                end
                default: begin
                    @(negedge clk);
                    check_value(names[i], ops[i].exp, {24'b0, uo_out});
                end
            endcase
        end

        $display("Checks %0d, value errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- periph_hub.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module periph_hub (
    input  logic                         clk,
    input  logic                         rst_n,
    input  periph_pin_pkg::pin_vec_t     i_ui_in,
    output periph_pin_pkg::pin_vec_t     o_uo_out,
    input  logic [`PH_ADDR_W-1:0]        i_addr,
    input  logic [`PH_DATA_W-1:0]        i_wdata,
    input  periph_bus_pkg::access_size_e i_write_n,
    input  periph_bus_pkg::access_size_e i_read_n,
    input  logic                         i_read_complete,
    output logic [`PH_DATA_W-1:0]        o_rdata,
    output logic                         o_data_ready
);

    import periph_bus_pkg::*;
    import periph_pin_pkg::*;

    bus_req_t                                       req;
    logic [`PH_DATA_W-1:0]                          gpio_rdata;
    logic [`PH_BYTE_SLOTS_USED-1:0][`PH_BYTE_W-1:0] byte_rdata;
    pin_vec_t                                       gpio_pins;
    pin_vec_t [`PH_BYTE_SLOTS_USED-1:0]             byte_pins;
    fsel_t [`PH_PINS-1:0]                           fsel;

    // Input side
    periph_addr_decode u_decode (
        .i_addr    (i_addr),
        .i_wdata   (i_wdata),
        .i_write_n (i_write_n),
        .i_read_n  (i_read_n),
        .o_req     (req)
    );

    // Peripherals
    gpio_periph u_gpio (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (req),
        .i_ui_in (i_ui_in),
        .o_rdata (gpio_rdata),
        .o_pins  (gpio_pins),
        .o_fsel  (fsel)
    );

    for (genvar s = 0; s < `PH_BYTE_SLOTS_USED; s++) begin : g_byte
        byte_reg_periph #(
            .SLOT (s)
        ) u_byte (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_req   (req),
            .i_ui_in (i_ui_in),
            .o_rdata (byte_rdata[s]),
            .o_pins  (byte_pins[s])
        );
    end

    // Output side
    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_gpio_rdata    (gpio_rdata),
        .i_byte_rdata    (byte_rdata),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_data_ready    (o_data_ready)
    );

    pin_output_mux u_pin_mux (
        .i_fsel      (fsel),
        .i_gpio_pins (gpio_pins),
        .i_byte_pins (byte_pins),
        .o_uo_out    (o_uo_out)
    );

endmodule

//--- pin_output_mux.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module pin_output_mux (
    input  periph_pin_pkg::fsel_t [`PH_PINS-1:0]               i_fsel,
    input  periph_pin_pkg::pin_vec_t                           i_gpio_pins,
    input  periph_pin_pkg::pin_vec_t [`PH_BYTE_SLOTS_USED-1:0] i_byte_pins,
    output periph_pin_pkg::pin_vec_t                           o_uo_out
);

    // Pin p always takes bit p of the peripheral its select names
    always_comb begin
        o_uo_out = '0;
        for (int p = 0; p < `PH_PINS; p++) begin
            if (i_fsel[p].from_byte_region) begin
                for (int s = 0; s < `PH_BYTE_SLOTS_USED; s++) begin
                    if (i_fsel[p].slot == s) begin
                        o_uo_out[p] = i_byte_pins[s][p];
                    end
                end
            end else if (i_fsel[p].slot == `PH_GPIO_SLOT) begin
                o_uo_out[p] = i_gpio_pins[p];
            end
            // Any other slot has no peripheral and leaves the pin low
        end
    end

endmodule

//--- read_return.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module read_return (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  periph_bus_pkg::bus_req_t                      i_req,
    input  logic [`PH_DATA_W-1:0]                         i_gpio_rdata,
    input  logic [`PH_BYTE_SLOTS_USED-1:0][`PH_BYTE_W-1:0] i_byte_rdata,
    input  logic                                          i_read_complete,
    output logic [`PH_DATA_W-1:0]                         o_rdata,
    output logic                                          o_data_ready
);

    localparam int PAD_W = `PH_DATA_W - `PH_BYTE_W;

    logic [`PH_DATA_W-1:0] rdata_mux;
    logic [`PH_DATA_W-1:0] rdata_q;
    logic                  hold_q;
    logic                  ready_q;
    logic                  capture;

    // Unused slots in either region read as zero
    always_comb begin
        rdata_mux = '0;
        if (i_req.is_byte_region) begin
            for (int s = 0; s < `PH_BYTE_SLOTS_USED; s++) begin
                if (i_req.slot == s) begin
                    rdata_mux = {{PAD_W{1'b0}}, i_byte_rdata[s]};
                end
            end
        end else if (i_req.slot == `PH_GPIO_SLOT) begin
            rdata_mux = i_gpio_rdata;
        end
    end

    // Take a new value only when nothing is waiting for the core
    assign capture = !hold_q && i_req.rd;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Every kept peripheral answers at once, so ready follows the request
            ready_q <= i_req.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= rdata_mux;
        end
    end

    assign o_rdata      = rdata_q;
    // Writes complete in the cycle they are presented
    assign o_data_ready = ready_q || i_req.wr;

endmodule

//--- byte_reg_periph.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module byte_reg_periph #(
    parameter int SLOT = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  periph_bus_pkg::bus_req_t i_req,
    input  periph_pin_pkg::pin_vec_t i_ui_in,
    output logic [`PH_BYTE_W-1:0]    o_rdata,
    output periph_pin_pkg::pin_vec_t o_pins
);

    import periph_pin_pkg::*;

    pin_vec_t                  out_q;
    logic                      sel;
    logic [`PH_BYTE_OFS_W-1:0] ofs;

    assign sel = i_req.is_byte_region && (i_req.slot == SLOT);
    assign ofs = i_req.offset[`PH_BYTE_OFS_W-1:0];

    // Only the low byte of the write data reaches a byte slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (sel && i_req.wr && (ofs == 4'h0)) begin
            out_q <= i_req.wdata[`PH_BYTE_W-1:0];
        end
    end

    always_comb begin
        case (ofs)
            4'h0:    o_rdata = out_q;
            4'h1:    o_rdata = i_ui_in;
            default: o_rdata = '0;
        endcase
    end

    assign o_pins = out_q;

endmodule

//--- gpio_periph.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module gpio_periph (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  periph_bus_pkg::bus_req_t               i_req,
    input  periph_pin_pkg::pin_vec_t               i_ui_in,
    output logic [`PH_DATA_W-1:0]                  o_rdata,
    output periph_pin_pkg::pin_vec_t               o_pins,
    output periph_pin_pkg::fsel_t [`PH_PINS-1:0]   o_fsel
);

    import periph_pin_pkg::*;

    localparam int FSEL_W = $bits(fsel_t);

    pin_vec_t                      gpio_out;
    fsel_t [`PH_PINS-1:0]          fsel_q;
    logic                          sel;
    logic                          out_hit;
    logic                          in_hit;
    logic                          fsel_hit;
    logic [$clog2(`PH_PINS)-1:0]   fsel_idx;

    assign sel = !i_req.is_byte_region && (i_req.slot == `PH_GPIO_SLOT);

    // Offset 0 output, offset 4 input, 32..60 one select per pin
    assign out_hit  = (i_req.offset == 6'h00);
    assign in_hit   = (i_req.offset == 6'h04);
    assign fsel_hit = i_req.offset[5] && (i_req.offset[1:0] == 2'b00);
    assign fsel_idx = i_req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < `PH_PINS; i++) begin
                fsel_q[i] <= `PH_FSEL_RESET;
            end
        end else if (sel && i_req.wr) begin
            if (out_hit) begin
                gpio_out <= i_req.wdata[`PH_PINS-1:0];
            end
            if (fsel_hit) begin
                fsel_q[fsel_idx] <= i_req.wdata[FSEL_W-1:0];
            end
        end
    end

    // The read return picks this slot by address
    always_comb begin
        o_rdata = '0;
        if (out_hit) begin
            o_rdata[`PH_PINS-1:0] = gpio_out;
        end else if (in_hit) begin
            o_rdata[`PH_PINS-1:0] = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[FSEL_W-1:0] = fsel_q[fsel_idx];
        end
    end

    assign o_pins = gpio_out;
    assign o_fsel = fsel_q;

endmodule

//--- periph_addr_decode.sv
`timescale 1ns/1ps

`include "periph_hub_cfg.svh"

module periph_addr_decode (
    input  periph_bus_pkg::periph_addr_u i_addr,
    input  logic [`PH_DATA_W-1:0]        i_wdata,
    input  periph_bus_pkg::access_size_e i_write_n,
    input  periph_bus_pkg::access_size_e i_read_n,
    output periph_bus_pkg::bus_req_t     o_req
);

    import periph_bus_pkg::*;

    localparam int OFS_PAD = `PH_WORD_OFS_W - `PH_BYTE_OFS_W;

    logic region;

    // Region bit sits at the top of both views
    assign region = i_addr.word_view.region;

    always_comb begin
        o_req = '0;
        o_req.is_byte_region = region;

        if (region) begin
            o_req.slot   = i_addr.byte_view.slot;
            // Byte slots are only 16 bytes wide
            o_req.offset = {{OFS_PAD{1'b0}}, i_addr.byte_view.offset};
        end else begin
            o_req.slot   = i_addr.word_view.slot;
            o_req.offset = i_addr.word_view.offset;
        end

        // Any size code other than idle counts as an access
        o_req.wr    = (i_write_n != ACC_NONE);
        o_req.rd    = (i_read_n != ACC_NONE);
        o_req.wdata = i_wdata;
    end

endmodule

//--- periph_pin_pkg.sv
`include "periph_hub_cfg.svh"

package periph_pin_pkg;

    // One bit per output or input pin
    typedef logic [`PH_PINS-1:0] pin_vec_t;

    // Names the peripheral that drives one output pin
    typedef struct packed {
        logic                  from_byte_region;
        logic [`PH_SLOT_W-1:0] slot;
    } fsel_t;

endpackage

//--- periph_bus_pkg.sv
`include "periph_hub_cfg.svh"

package periph_bus_pkg;

    // All ones in a size code means no access this cycle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_size_e;

    // Word region view with 64-byte slots
    typedef struct packed {
        logic                      region;
        logic [`PH_SLOT_W-1:0]     slot;
        logic [`PH_WORD_OFS_W-1:0] offset;
    } word_addr_t;

    // Byte region view with 16-byte slots and bits 9:8 ignored
    typedef struct packed {
        logic                                                 region;
        logic [`PH_ADDR_W-2-`PH_SLOT_W-`PH_BYTE_OFS_W:0]      rsvd;
        logic [`PH_SLOT_W-1:0]                                slot;
        logic [`PH_BYTE_OFS_W-1:0]                            offset;
    } byte_addr_t;

    // The top bit tells which view of the address word applies
    typedef union packed {
        word_addr_t word_view;
        byte_addr_t byte_view;
    } periph_addr_u;

    // Request as seen by every peripheral and the read return
    typedef struct packed {
        logic                      is_byte_region;
        logic [`PH_SLOT_W-1:0]     slot;
        logic [`PH_WORD_OFS_W-1:0] offset;
        logic                      wr;
        logic                      rd;
        logic [`PH_DATA_W-1:0]     wdata;
    } bus_req_t;

endpackage

//--- periph_hub_cfg.svh
`ifndef PERIPH_HUB_CFG_SVH
`define PERIPH_HUB_CFG_SVH

// Core data bus
`define PH_ADDR_W 11
`define PH_DATA_W 32

// Width of the in and out pin ports
`define PH_PINS 8

// Byte region peripherals move one byte per access
`define PH_BYTE_W 8

// Slot layout of the two regions
`define PH_WORD_SLOTS 16
`define PH_SLOT_W ($clog2(`PH_WORD_SLOTS))
`define PH_WORD_OFS_W 6
`define PH_BYTE_OFS_W 4
`define PH_BYTE_SLOTS_USED 2
`define PH_GPIO_SLOT 1

// Every pin starts on the GPIO output register in word slot 1
`define PH_FSEL_RESET 5'b0_0001

`endif
